//--- include/i2c_consts.svh
`ifndef I2C_CONSTS_SVH
`define I2C_CONSTS_SVH

// ----------------------------------------------------------------------
// Register map, 3-bit word address
// ----------------------------------------------------------------------
`define I2C_ADR_STATUS   3'd0
`define I2C_ADR_CONTROL  3'd1
`define I2C_ADR_SEND     3'd2
`define I2C_ADR_RECV     3'd3
`define I2C_ADR_DIVIDER  3'd4

// Control register bits
`define I2C_CTL_START    0
`define I2C_CTL_STOP     1
`define I2C_CTL_RECV     2
`define I2C_CTL_NACK     3

// Status register bits
`define I2C_ST_BUSY      0
`define I2C_ST_ACKERR    1
`define I2C_ST_SDA_T     4
`define I2C_ST_SCL_T     5
`define I2C_ST_SDA       6
`define I2C_ST_SCL       7

// Quarter period is divider + 1 clocks
`define I2C_DIV_WIDTH    16
`define I2C_DIV_INIT     250

`define I2C_WB_DAT_WIDTH 32

`endif

//--- rtl/i2c_pkg.sv
package i2c_pkg;

	// ----------------------------------------------------------------------
	// Commands from the byte engine to the bit engine
	// ----------------------------------------------------------------------
	typedef enum logic [2:0] {
		BIT_IDLE  = 3'd0,
		BIT_START = 3'd1,
		BIT_STOP  = 3'd2,
		BIT_WRITE = 3'd3,
		BIT_READ  = 3'd4
	} bit_cmd_e;

	// ----------------------------------------------------------------------
	// Byte engine FSM
	// ----------------------------------------------------------------------
	typedef enum logic [2:0] {
		ST_IDLE  = 3'd0,
		ST_START = 3'd1,
		ST_STOP  = 3'd2,
		// Eight data bits
		ST_SHIFT = 3'd3,
		// Ninth bit, acknowledge in either direction
		ST_ACK   = 3'd4
	} byte_state_e;

endpackage

//--- rtl/i2c_regs.sv
`timescale 1ns/1ps
`include "i2c_consts.svh"

module i2c_regs (
	input  logic                         clk,
	input  logic                         reset,

	input  logic                         wb_cyc_i,
	input  logic                         wb_stb_i,
	input  logic                         wb_we_i,
	input  logic [2:0]                   wb_adr_i,
	input  logic [`I2C_WB_DAT_WIDTH-1:0] wb_dat_i,
	output logic [`I2C_WB_DAT_WIDTH-1:0] wb_dat_o,
	output logic                         wb_ack_o,

	input  logic                         busy_i,
	input  logic                         ack_err_i,
	input  logic [7:0]                   recv_data_i,
	input  logic                         scl_t_i,
	input  logic                         sda_t_i,
	input  logic                         scl_i,
	input  logic                         sda_i,

	output logic [`I2C_DIV_WIDTH-1:0]    divider_o,
	output logic                         cmd_start_o,
	output logic                         cmd_stop_o,
	output logic                         cmd_send_o,
	output logic                         cmd_recv_o,
	output logic [7:0]                   send_data_o,
	output logic                         ack_out_o
);

	logic wr_en;
	logic ctl_wr;

	// Zero-wait slave, every strobe is acknowledged at once
	assign wb_ack_o = wb_cyc_i & wb_stb_i;
	assign wr_en    = wb_ack_o & wb_we_i;
	assign ctl_wr   = wr_en & (wb_adr_i == `I2C_ADR_CONTROL);

	// ----------------------------------------------------------------------
	// Command pulses, valid in the cycle of the acknowledged write
	// ----------------------------------------------------------------------
	assign cmd_start_o = ctl_wr & wb_dat_i[`I2C_CTL_START];
	assign cmd_stop_o  = ctl_wr & wb_dat_i[`I2C_CTL_STOP];
	assign cmd_recv_o  = ctl_wr & wb_dat_i[`I2C_CTL_RECV];
	assign cmd_send_o  = wr_en & (wb_adr_i == `I2C_ADR_SEND);
	assign send_data_o = wb_dat_i[7:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			divider_o <= `I2C_DIV_WIDTH'(`I2C_DIV_INIT);
			ack_out_o <= 1'b0;
		end else begin
			if (wr_en && wb_adr_i == `I2C_ADR_DIVIDER) begin
				divider_o <= wb_dat_i[`I2C_DIV_WIDTH-1:0];
			end
			// Acknowledge level for the byte being received
			if (cmd_recv_o) begin
				ack_out_o <= wb_dat_i[`I2C_CTL_NACK];
			end
		end
	end

	// ----------------------------------------------------------------------
	// Read data
	// ----------------------------------------------------------------------
	always_comb begin
		wb_dat_o = '0;
		case (wb_adr_i)
			`I2C_ADR_STATUS: begin
				wb_dat_o[`I2C_ST_BUSY]   = busy_i;
				wb_dat_o[`I2C_ST_ACKERR] = ack_err_i;
				wb_dat_o[`I2C_ST_SDA_T]  = sda_t_i;
				wb_dat_o[`I2C_ST_SCL_T]  = scl_t_i;
				wb_dat_o[`I2C_ST_SDA]    = sda_i;
				wb_dat_o[`I2C_ST_SCL]    = scl_i;
			end
			`I2C_ADR_CONTROL: begin
				wb_dat_o[`I2C_CTL_NACK] = ack_out_o;
			end
			`I2C_ADR_RECV: begin
				wb_dat_o[7:0] = recv_data_i;
			end
			`I2C_ADR_DIVIDER: begin
				wb_dat_o[`I2C_DIV_WIDTH-1:0] = divider_o;
			end
			default: begin
				wb_dat_o = '0;
			end
		endcase
	end

endmodule

//--- rtl/i2c_byte_engine.sv
`timescale 1ns/1ps

module i2c_byte_engine (
	input  logic              clk,
	input  logic              reset,

	input  logic              cmd_start_i,
	input  logic              cmd_stop_i,
	input  logic              cmd_send_i,
	input  logic              cmd_recv_i,
	input  logic [7:0]        send_data_i,
	input  logic              ack_out_i,

	input  logic              bit_done_i,
	input  logic              bit_rxd_i,
	output logic              bit_go_o,
	output i2c_pkg::bit_cmd_e bit_cmd_o,
	output logic              bit_txd_o,

	output logic              busy_o,
	output logic [7:0]        recv_data_o,
	output logic              ack_err_o
);

	i2c_pkg::byte_state_e state;
	logic [2:0]           bit_cnt;
	logic [7:0]           shreg;
	logic                 recv_mode;

	assign busy_o = (state != i2c_pkg::ST_IDLE);

	// ----------------------------------------------------------------------
	// FSM, one bit command in flight at a time
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= i2c_pkg::ST_IDLE;
			bit_go_o  <= 1'b0;
			bit_cmd_o <= i2c_pkg::BIT_IDLE;
			recv_mode <= 1'b0;
			ack_err_o <= 1'b0;
		end else begin
			bit_go_o <= 1'b0;
			case (state)
				i2c_pkg::ST_IDLE: begin
					// Start wins if several bits are set in one write
					if (cmd_start_i) begin
						state     <= i2c_pkg::ST_START;
						bit_cmd_o <= i2c_pkg::BIT_START;
						bit_go_o  <= 1'b1;
					end else if (cmd_send_i || cmd_recv_i) begin
						state     <= i2c_pkg::ST_SHIFT;
						recv_mode <= ~cmd_send_i;
						bit_cmd_o <= cmd_send_i ? i2c_pkg::BIT_WRITE : i2c_pkg::BIT_READ;
						bit_go_o  <= 1'b1;
					end else if (cmd_stop_i) begin
						state     <= i2c_pkg::ST_STOP;
						bit_cmd_o <= i2c_pkg::BIT_STOP;
						bit_go_o  <= 1'b1;
					end
				end
				i2c_pkg::ST_SHIFT: begin
					if (bit_done_i) begin
						bit_go_o <= 1'b1;
						if (bit_cnt == 3'd0) begin
							state     <= i2c_pkg::ST_ACK;
							// Master drives the ack after a read, samples it after a write
							bit_cmd_o <= recv_mode ? i2c_pkg::BIT_WRITE : i2c_pkg::BIT_READ;
						end
					end
				end
				i2c_pkg::ST_ACK: begin
					if (bit_done_i) begin
						state <= i2c_pkg::ST_IDLE;
						if (!recv_mode) begin
							ack_err_o <= bit_rxd_i;
						end
					end
				end
				default: begin
					// START and STOP are a single bit command
					if (bit_done_i) begin
						state <= i2c_pkg::ST_IDLE;
					end
				end
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// Data path, MSB first in both directions
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (state == i2c_pkg::ST_IDLE) begin
			bit_cnt   <= 3'd7;
			shreg     <= send_data_i;
			bit_txd_o <= cmd_send_i ? send_data_i[7] : 1'b1;
		end else if (state == i2c_pkg::ST_SHIFT && bit_done_i) begin
			bit_cnt   <= bit_cnt - 3'd1;
			shreg     <= {shreg[6:0], bit_rxd_i};
			bit_txd_o <= recv_mode ? 1'b1 : shreg[6];
			if (bit_cnt == 3'd0) begin
				bit_txd_o <= recv_mode ? ack_out_i : 1'b1;
				if (recv_mode) begin
					recv_data_o <= {shreg[6:0], bit_rxd_i};
				end
			end
		end
	end

endmodule

//--- rtl/i2c_bit_engine.sv
`timescale 1ns/1ps
`include "i2c_consts.svh"

module i2c_bit_engine (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [`I2C_DIV_WIDTH-1:0] divider_i,

	input  logic                      bit_go_i,
	input  i2c_pkg::bit_cmd_e         bit_cmd_i,
	input  logic                      bit_txd_i,

	input  logic                      scl_i,
	input  logic                      sda_i,
	output logic                      scl_t_o,
	output logic                      sda_t_o,

	output logic                      bit_done_o,
	output logic                      bit_rxd_o
);

	i2c_pkg::bit_cmd_e         cmd;
	logic                      txd;
	logic                      active;
	logic [1:0]                phase;
	logic [`I2C_DIV_WIDTH-1:0] qcnt;
	logic                      stretch;
	logic                      quarter_end;
	logic                      last_quarter;

	// Index of the final quarter of each command
	function automatic logic [1:0] last_phase(input i2c_pkg::bit_cmd_e c);
		case (c)
			i2c_pkg::BIT_START: return 2'd1;
			i2c_pkg::BIT_STOP:  return 2'd2;
			default:            return 2'd3;
		endcase
	endfunction

	// Line enables for a quarter, {scl_t, sda_t}
	// Only one line moves per quarter boundary
	function automatic logic [1:0] line_pattern(
		input i2c_pkg::bit_cmd_e c,
		input logic [1:0]        ph,
		input logic              d,
		input logic              scl_now,
		input logic              sda_now
	);
		logic scl_n;
		logic sda_n;
		scl_n = scl_now;
		sda_n = sda_now;
		case (c)
			i2c_pkg::BIT_START: begin
				// Both released, then SDA falls while SCL stays high
				if (ph == 2'd0) begin
					scl_n = 1'b1;
					sda_n = 1'b1;
				end else begin
					sda_n = 1'b0;
				end
			end
			i2c_pkg::BIT_STOP: begin
				case (ph)
					2'd0:    scl_n = 1'b0;
					2'd1:    sda_n = 1'b0;
					default: scl_n = 1'b1;
				endcase
			end
			i2c_pkg::BIT_WRITE, i2c_pkg::BIT_READ: begin
				case (ph)
					2'd0:    scl_n = 1'b0;
					2'd1:    sda_n = (c == i2c_pkg::BIT_READ) ? 1'b1 : d;
					default: scl_n = 1'b1;
				endcase
			end
			default: begin
				scl_n = scl_now;
			end
		endcase
		return {scl_n, sda_n};
	endfunction

	// Slave holds SCL low after release
	assign stretch      = scl_t_o & ~scl_i;
	assign quarter_end  = active & ~stretch & (qcnt == '0);
	assign last_quarter = (phase == last_phase(cmd));

	// ----------------------------------------------------------------------
	// Quarter counter and phase sequencing
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			active     <= 1'b0;
			phase      <= 2'd0;
			qcnt       <= '0;
			scl_t_o    <= 1'b1;
			sda_t_o    <= 1'b1;
			bit_done_o <= 1'b0;
		end else begin
			bit_done_o <= 1'b0;
			if (!active) begin
				if (bit_go_i) begin
					active <= 1'b1;
					phase  <= 2'd0;
					qcnt   <= divider_i;
					{scl_t_o, sda_t_o} <= line_pattern(bit_cmd_i, 2'd0, bit_txd_i,
						scl_t_o, sda_t_o);
				end
			end else if (!stretch) begin
				if (qcnt != '0) begin
					qcnt <= qcnt - 1'b1;
				end else if (last_quarter) begin
					active     <= 1'b0;
					bit_done_o <= 1'b1;
					// Rising SDA with SCL high ends the STOP
					if (cmd == i2c_pkg::BIT_STOP) begin
						sda_t_o <= 1'b1;
					end
				end else begin
					phase <= phase + 2'd1;
					qcnt  <= divider_i;
					{scl_t_o, sda_t_o} <= line_pattern(cmd, phase + 2'd1, txd,
						scl_t_o, sda_t_o);
				end
			end
		end
	end

	// Command latch and SDA sample at the end of the third quarter
	always_ff @(posedge clk) begin
		if (!active && bit_go_i) begin
			cmd <= bit_cmd_i;
			txd <= bit_txd_i;
		end
		if (quarter_end && phase == 2'd2) begin
			bit_rxd_o <= sda_i;
		end
	end

endmodule

//--- rtl/i2c_master_top.sv
`timescale 1ns/1ps
`include "i2c_consts.svh"

module i2c_master_top (
	input  logic                         clk,
	input  logic                         reset,

	input  logic                         wb_cyc_i,
	input  logic                         wb_stb_i,
	input  logic                         wb_we_i,
	input  logic [2:0]                   wb_adr_i,
	input  logic [`I2C_WB_DAT_WIDTH-1:0] wb_dat_i,
	output logic [`I2C_WB_DAT_WIDTH-1:0] wb_dat_o,
	output logic                         wb_ack_o,

	output logic                         scl_t_o,
	output logic                         sda_t_o,
	input  logic                         scl_i,
	input  logic                         sda_i
);

	logic [`I2C_DIV_WIDTH-1:0] divider;
	logic                      cmd_start;
	logic                      cmd_stop;
	logic                      cmd_send;
	logic                      cmd_recv;
	logic [7:0]                send_data;
	logic                      ack_out;
	logic                      busy;
	logic [7:0]                recv_data;
	logic                      ack_err;
	logic                      bit_go;
	i2c_pkg::bit_cmd_e         bit_cmd;
	logic                      bit_txd;
	logic                      bit_done;
	logic                      bit_rxd;

	// ----------------------------------------------------------------------
	// Register block
	// ----------------------------------------------------------------------
	i2c_regs regs_i (
		.clk         (clk),
		.reset       (reset),
		.wb_cyc_i    (wb_cyc_i),
		.wb_stb_i    (wb_stb_i),
		.wb_we_i     (wb_we_i),
		.wb_adr_i    (wb_adr_i),
		.wb_dat_i    (wb_dat_i),
		.wb_dat_o    (wb_dat_o),
		.wb_ack_o    (wb_ack_o),
		.busy_i      (busy),
		.ack_err_i   (ack_err),
		.recv_data_i (recv_data),
		.scl_t_i     (scl_t_o),
		.sda_t_i     (sda_t_o),
		.scl_i       (scl_i),
		.sda_i       (sda_i),
		.divider_o   (divider),
		.cmd_start_o (cmd_start),
		.cmd_stop_o  (cmd_stop),
		.cmd_send_o  (cmd_send),
		.cmd_recv_o  (cmd_recv),
		.send_data_o (send_data),
		.ack_out_o   (ack_out)
	);

	// ----------------------------------------------------------------------
	// Byte and bit engines
	// ----------------------------------------------------------------------
	i2c_byte_engine byte_i (
		.clk         (clk),
		.reset       (reset),
		.cmd_start_i (cmd_start),
		.cmd_stop_i  (cmd_stop),
		.cmd_send_i  (cmd_send),
		.cmd_recv_i  (cmd_recv),
		.send_data_i (send_data),
		.ack_out_i   (ack_out),
		.bit_done_i  (bit_done),
		.bit_rxd_i   (bit_rxd),
		.bit_go_o    (bit_go),
		.bit_cmd_o   (bit_cmd),
		.bit_txd_o   (bit_txd),
		.busy_o      (busy),
		.recv_data_o (recv_data),
		.ack_err_o   (ack_err)
	);

	i2c_bit_engine bit_i (
		.clk        (clk),
		.reset      (reset),
		.divider_i  (divider),
		.bit_go_i   (bit_go),
		.bit_cmd_i  (bit_cmd),
		.bit_txd_i  (bit_txd),
		.scl_i      (scl_i),
		.sda_i      (sda_i),
		.scl_t_o    (scl_t_o),
		.sda_t_o    (sda_t_o),
		.bit_done_o (bit_done),
		.bit_rxd_o  (bit_rxd)
	);

endmodule

//--- bench/i2c_slave_model.sv
`timescale 1ns/1ps

module i2c_slave_model #(
	parameter logic [6:0] ADDR    = 7'h50,
	parameter int         STRETCH = 20
) (
	input  logic clk,
	input  logic reset,
	input  logic scl_i,
	input  logic sda_i,
	output logic scl_t_o,
	output logic sda_t_o
);

	logic [7:0] mem [0:3];
	logic       scl_q;
	logic       sda_q;
	logic       listening;
	logic       first;
	logic       active;
	logic       rw;
	logic       in_ack;
	logic       master_nack;
	logic [3:0] bit_cnt;
	logic [7:0] shreg;
	logic [7:0] txreg;
	logic [1:0] ptr;
	int         stretch_cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			scl_q <= 1'b1;
			sda_q <= 1'b1;
			scl_t_o <= 1'b1;
			sda_t_o <= 1'b1;
			listening <= 1'b0;
			in_ack <= 1'b0;
			stretch_cnt <= 0;
			for (int i = 0; i < 4; i++) begin
				mem[i] <= 8'hc3 ^ 8'(i * 37);
			end
		end else begin
			scl_q <= scl_i;
			sda_q <= sda_i;
			if (stretch_cnt > 0) begin
				stretch_cnt <= stretch_cnt - 1;
				if (stretch_cnt == 1) begin
					scl_t_o <= 1'b1;
				end
			end
			if (scl_i && scl_q && sda_q && !sda_i) begin
				// START, the address byte follows
				listening <= 1'b1;
				first <= 1'b1;
				active <= 1'b0;
				in_ack <= 1'b0;
				bit_cnt <= 4'd0;
				ptr <= 2'd0;
				sda_t_o <= 1'b1;
			end else if (scl_i && scl_q && !sda_q && sda_i) begin
				listening <= 1'b0;
				sda_t_o <= 1'b1;
			end else if (listening && !scl_q && scl_i) begin
				if (in_ack) begin
					master_nack <= sda_i;
				end else if (bit_cnt < 4'd8) begin
					shreg <= {shreg[6:0], sda_i};
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else if (listening && scl_q && !scl_i) begin
				// Hold SCL low so the master's next release has to wait
				scl_t_o <= 1'b0;
				stretch_cnt <= STRETCH;
				if (bit_cnt == 4'd8 && !in_ack) begin
					in_ack <= 1'b1;
					master_nack <= 1'b0;
					sda_t_o <= 1'b1;
					if (first) begin
						first <= 1'b0;
						active <= (shreg[7:1] == ADDR);
						rw <= shreg[0];
						if (shreg[7:1] == ADDR) begin
							sda_t_o <= 1'b0;
						end
					end else if (active && !rw) begin
						mem[ptr] <= shreg;
						ptr <= ptr + 2'd1;
						sda_t_o <= 1'b0;
					end
				end else if (in_ack) begin
					in_ack <= 1'b0;
					bit_cnt <= 4'd0;
					sda_t_o <= 1'b1;
					if (active && rw && !master_nack) begin
						txreg <= mem[ptr];
						sda_t_o <= mem[ptr][7];
						ptr <= ptr + 2'd1;
					end
				end else if (active && rw && bit_cnt != 4'd0) begin
					sda_t_o <= txreg[3'd7 - bit_cnt[2:0]];
				end
			end
		end
	end

endmodule

//--- bench/i2c_properties.sv
`timescale 1ns/1ps

module i2c_properties (
	input logic              clk,
	input logic              reset,
	input logic              wb_cyc_i,
	input logic              wb_stb_i,
	input logic              wb_ack_o,
	input logic              scl_t_o,
	input logic              sda_t_o,
	input logic              scl_i,
	input logic              busy,
	input i2c_pkg::bit_cmd_e bit_cmd
);

	// Zero-wait acknowledge
	ack_follows_strobe: assert property (@(posedge clk)
		wb_ack_o == (wb_cyc_i && wb_stb_i))
		else $error("wb_ack_o differs from cyc and stb");

	lines_released_in_reset: assert property (@(posedge clk)
		(reset && $past(reset)) |-> (scl_t_o && sda_t_o))
		else $error("line enable low during reset");

	// Data may only move while SCL is low, START and STOP aside
	sda_stable_scl_high: assert property (@(posedge clk) disable iff (reset)
		(scl_i && $past(scl_i) && busy && bit_cmd != i2c_pkg::BIT_START
			&& bit_cmd != i2c_pkg::BIT_STOP) |-> $stable(sda_t_o))
		else $error("sda_t_o changed while SCL high");

endmodule

//--- bench/i2c_tb.sv
`timescale 1ns/1ps
`include "i2c_consts.svh"

module i2c_tb;

	localparam int STRETCH = 20;

	logic                         clk;
	logic                         reset;
	logic                         wb_cyc;
	logic                         wb_stb;
	logic                         wb_we;
	logic [2:0]                   wb_adr;
	logic [`I2C_WB_DAT_WIDTH-1:0] wb_dat_w;
	logic [`I2C_WB_DAT_WIDTH-1:0] wb_dat_r;
	logic                         wb_ack;
	logic                         m_scl_t;
	logic                         m_sda_t;
	logic                         s_scl_t;
	logic                         s_sda_t;
	logic                         scl;
	logic                         sda;

	string       ops[$];
	logic [31:0] datas[$];
	logic [31:0] exps[$];
	int          n_tests;
	int          pass_cnt;
	int          fail_cnt;
	logic [7:0]  rand_byte;

	// Open-drain lines
	assign scl = m_scl_t & s_scl_t;
	assign sda = m_sda_t & s_sda_t;

	i2c_master_top dut_i (
		.clk      (clk),
		.reset    (reset),
		.wb_cyc_i (wb_cyc),
		.wb_stb_i (wb_stb),
		.wb_we_i  (wb_we),
		.wb_adr_i (wb_adr),
		.wb_dat_i (wb_dat_w),
		.wb_dat_o (wb_dat_r),
		.wb_ack_o (wb_ack),
		.scl_t_o  (m_scl_t),
		.sda_t_o  (m_sda_t),
		.scl_i    (scl),
		.sda_i    (sda)
	);

	i2c_slave_model #(.ADDR(7'h50), .STRETCH(STRETCH)) slave_i (
		.clk     (clk),
		.reset   (reset),
		.scl_i   (scl),
		.sda_i   (sda),
		.scl_t_o (s_scl_t),
		.sda_t_o (s_sda_t)
	);

	bind i2c_master_top i2c_properties props_i (
		.clk      (clk),
		.reset    (reset),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_ack_o (wb_ack_o),
		.scl_t_o  (scl_t_o),
		.sda_t_o  (sda_t_o),
		.scl_i    (scl_i),
		.busy     (busy),
		.bit_cmd  (bit_cmd)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ------------------------------------------------------------------
	// Wishbone access and status polling
	// ------------------------------------------------------------------
	task automatic wb_write(input logic [2:0] adr, input logic [31:0] dat);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b1;
		wb_adr <= adr;
		wb_dat_w <= dat;
		@(negedge clk);
		if (wb_ack !== 1'b1) begin
			$display("Wishbone write to address %0d was not acknowledged", adr);
			fail_cnt++;
		end
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic wb_read(input logic [2:0] adr, output logic [31:0] dat);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b0;
		wb_adr <= adr;
		@(negedge clk);
		dat = wb_dat_r;
		if (wb_ack !== 1'b1) begin
			$display("Wishbone read from address %0d was not acknowledged", adr);
			fail_cnt++;
		end
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
	endtask

	task automatic wait_idle();
		logic [31:0] st;
		st = 32'h1;
		while (st[`I2C_ST_BUSY]) begin
			wb_read(`I2C_ADR_STATUS, st);
		end
	endtask

	// ------------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------------
	task automatic check_data(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("Fail %s expected %02h actual %02h", name, exp, act);
			fail_cnt++;
		end else begin
			$display("ok   %s %02h", name, act);
			pass_cnt++;
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("Fail %s expected %08h actual %08h", name, exp, act);
			fail_cnt++;
		end else begin
			$display("ok   %s %08h", name, act);
			pass_cnt++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail %s expected %b actual %b", name, exp, act);
			fail_cnt++;
		end else begin
			$display("ok   %s %b", name, act);
			pass_cnt++;
		end
	endtask

	task automatic send_byte(input string name, input logic [7:0] b, input logic exp,
		input logic while_busy);
		logic [31:0] st;
		wb_write(`I2C_ADR_SEND, {24'h0, b});
		// Second byte lands while the first is still on the bus
		if (while_busy) begin
			wb_write(`I2C_ADR_SEND, {24'h0, ~b});
		end
		wait_idle();
		wb_read(`I2C_ADR_STATUS, st);
		check_flag(name, exp, st[`I2C_ST_ACKERR]);
	endtask

	task automatic run_test(input int idx);
		string       name;
		string       op;
		logic [31:0] d;
		logic [31:0] e;
		logic [31:0] rd;
		logic [31:0] line_mask;
		logic [31:0] lines;
		op = ops[idx];
		d = datas[idx];
		e = exps[idx];
		name = $sformatf("%0d_%s", idx, op);
		line_mask = (32'h1 << `I2C_ST_SCL) | (32'h1 << `I2C_ST_SCL_T)
			| (32'h1 << `I2C_ST_SDA) | (32'h1 << `I2C_ST_SDA_T);
		if (op == "rdiv" || op == "div") begin
			if (op == "div") begin
				wb_write(`I2C_ADR_DIVIDER, d);
			end
			wb_read(`I2C_ADR_DIVIDER, rd);
			check_word(name, e, rd);
		end else if (op == "status") begin
			wb_read(`I2C_ADR_STATUS, rd);
			check_word(name, e, rd);
		end else if (op == "start" || op == "stop") begin
			wb_write(`I2C_ADR_CONTROL, (op == "start") ? 32'h1 << `I2C_CTL_START
				: 32'h1 << `I2C_CTL_STOP);
			wait_idle();
			// START leaves SDA low under a high SCL
			lines = (32'h1 << `I2C_ST_SCL) | (32'h1 << `I2C_ST_SCL_T);
			// STOP releases both lines
			if (op == "stop") begin
				lines = line_mask;
			end
			wb_read(`I2C_ADR_STATUS, rd);
			check_word(name, lines, rd & line_mask);
		end else if (op == "send") begin
			send_byte(name, d[7:0], e[0], 1'b0);
		end else if (op == "sendr") begin
			send_byte(name, rand_byte, e[0], 1'b0);
		end else if (op == "sendbusy") begin
			send_byte(name, d[7:0], e[0], 1'b1);
		end else if (op == "recv") begin
			wb_write(`I2C_ADR_CONTROL, (32'h1 << `I2C_CTL_RECV)
				| (32'(d[0]) << `I2C_CTL_NACK));
			wait_idle();
			wb_read(`I2C_ADR_RECV, rd);
			check_data(name, e[7:0], rd[7:0]);
		end else if (op == "mem") begin
			check_data(name, e[7:0], slave_i.mem[d[1:0]]);
		end else if (op == "memr") begin
			check_data(name, rand_byte, slave_i.mem[d[1:0]]);
		end else begin
			$display("Unknown operation %s in test %0d of the test file", op, idx);
			fail_cnt++;
		end
	endtask

	task automatic load_tests();
		int          fd;
		int          n;
		string       line;
		string       op;
		logic [31:0] d;
		logic [31:0] e;
		fd = $fopen("bench/i2c_tests.txt", "r");
		if (fd == 0) begin
			$display("Cannot open bench/i2c_tests.txt");
			fail_cnt++;
		end else begin
			while ($fgets(line, fd)) begin
				n = $sscanf(line, "%s %h %h", op, d, e);
				if (n == 3 && line[0] != "#") begin
					ops.push_back(op);
					datas.push_back(d);
					exps.push_back(e);
				end
			end
			$fclose(fd);
		end
		n_tests = ops.size();
	endtask

	// ------------------------------------------------------------------
	// Main sequence and watchdog
	// ------------------------------------------------------------------
	initial begin
		longint limit_ns;
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 3'd0;
		wb_dat_w = '0;
		pass_cnt = 0;
		fail_cnt = 0;
		n_tests = 0;
		rand_byte = 8'($urandom(32'h0791b5b0));
		rand_byte = 8'($urandom());
		load_tests();
		// Ten bits per test and four quarters per bit with a margin of four
		limit_ns = longint'(n_tests + 1) * 10 * 4 * (`I2C_DIV_INIT + 1 + STRETCH) * 8 * 4;
		fork
			begin
				#(limit_ns);
				$display("Watchdog expired after %0d ns, a test did not finish", limit_ns);
				$display("Test failed");
				$finish;
			end
		join_none
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < n_tests; i++) begin
			run_test(i);
		end
		$display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- bench/i2c_tests.txt
# operation  data(hex)  expected(hex)
# send: expected is ack_err, recv: data is NACK, mem: data is slave index
rdiv     0    fa
div      4    4
status   0    f0
start    0    0
send     a0   0
send     3c   0
sendr    0    0
stop     0    0
mem      0    3c
memr     1    0
start    0    0
send     a1   0
recv     1    3c
stop     0    0
start    0    0
send     42   1
stop     0    0
status   0    f2
start    0    0
send     a0   0
sendbusy 5a   0
stop     0    0
mem      0    5a
memr     1    0
status   0    f0

//--- sources.f
+incdir+include
rtl/i2c_pkg.sv
rtl/i2c_regs.sv
rtl/i2c_byte_engine.sv
rtl/i2c_bit_engine.sv
rtl/i2c_master_top.sv
bench/i2c_slave_model.sv
bench/i2c_properties.sv
bench/i2c_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the I2C master testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module i2c_tb -o i2c_sim

output=$(./obj_dir/i2c_sim)
echo "$output"

echo "$output" | grep -q "Test completed successfully"
